// ==== verilog.f ====
logic/div_types_pkg.sv
logic/div_ctrl_pkg.sv
logic/div_operand_if.sv
logic/div_ctrl.sv
logic/div_operand_prep.sv
logic/div_radix4_unit.sv
logic/div_result_reg.sv
logic/div_top.sv
test/div_chk.sv
test/div_tb.sv

// ==== Makefile ====
SRCS := $(shell cat verilog.f)

.PHONY: run clean

run: obj_dir/Vdiv_tb
	./obj_dir/Vdiv_tb

obj_dir/Vdiv_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module div_tb -f verilog.f -o Vdiv_tb

clean:
	rm -rf obj_dir

// ==== test/div_tb.sv ====
// divider testbench
`timescale 1ns/10ps

module div_tb import div_types_pkg::*; ();

    // ------------------------------------------------------------------------
    // run constants
    // ------------------------------------------------------------------------

    localparam int          num_ops        = 300;
    localparam logic [31:0] seed           = 32'h46d8;
    // eight cycles per operation at most, plus reset and directed cases
    localparam int          timeout_cycles = num_ops * 8 + 100;
    // falling edges from the request edge to the out_vld sample
    localparam int          result_cycle   = 6;

    logic        clk;
    logic        rst_n;
    logic        in_vld;
    dividend_t   dividend;
    divisor_t    divisor;
    logic        busy;
    logic        out_vld;
    dividend_t   quo;
    divisor_t    rem;

    logic [31:0] lfsr;
    int          cycle_cnt;
    // junk requests during the busy window
    logic        stray_req;

    div_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the operations did not finish within %0d cycles", timeout_cycles);
        $display("Some tests failed");
        $fatal(1, "simulation timed out");
    end

    // ------------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------------

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit, msb drawn first
    task automatic draw_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic dividend_t model_quo(input dividend_t a, input divisor_t b);
        // divide by zero saturates
        if (b == '0) begin
            return '1;
        end
        return a / dividend_t'(b);
    endfunction

    function automatic divisor_t model_rem(input dividend_t a, input divisor_t b);
        if (b == '0) begin
            return a[divisor_w-1:0];
        end
        return divisor_t'(a % dividend_t'(b));
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_quo(input dividend_t got, input dividend_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: quo is %h, expected %h", $time, got, exp);
            $display("Some tests failed");
            $fatal(1, "quotient mismatch");
        end
    endtask

    task automatic check_rem(input divisor_t got, input divisor_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: rem is %h, expected %h", $time, got, exp);
            $display("Some tests failed");
            $fatal(1, "remainder mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "handshake mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // operation sequencing
    // ------------------------------------------------------------------------

    // quiet cycles, nothing may start or finish
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit("busy while idle", busy, 1'b0);
            check_bit("out_vld while idle", out_vld, 1'b0);
        end
    endtask

    // called on a falling edge, returns on the edge where busy drops
    task automatic run_op(input dividend_t a, input divisor_t b);
        int          cycles;
        logic        seen;
        logic [31:0] junk;
        dividend_t   exp_q;
        divisor_t    exp_r;
        exp_q = model_quo(a, b);
        exp_r = model_rem(a, b);
        check_bit("busy before request", busy, 1'b0);
        in_vld   = 1'b1;
        dividend = a;
        divisor  = b;
        cycles   = 0;
        seen     = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            seen = out_vld;
            check_bit("busy", busy, 1'b1);
            check_bit("out_vld", out_vld, cycles == result_cycle);
            // stray requests run through the done cycle too
            in_vld = stray_req;
            if (stray_req) begin
                draw_bits(28, junk);
                dividend = junk[27:12];
                divisor  = junk[11:0];
            end
        end
        check_quo(quo, exp_q);
        check_rem(rem, exp_r);
        @(negedge clk);
        check_bit("out_vld after result", out_vld, 1'b0);
        check_bit("busy after result", busy, 1'b0);
        in_vld = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] r;
        dividend_t   a;
        divisor_t    b;
        int          i;
        in_vld    = 1'b0;
        dividend  = '0;
        divisor   = '0;
        rst_n     = 1'b0;
        stray_req = 1'b0;
        lfsr      = seed;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(3);

        // edge operands
        run_op(16'h1234, 12'd1);
        run_op(16'hbeef, 12'd0);
        run_op(16'h0000, 12'd0);
        run_op(16'd100, 12'd4000);
        run_op(16'hffff, 12'hfff);
        run_op(16'h0000, 12'd37);
        run_op(16'hffff, 12'd1);
        idle_cycles(2);

        // requests while busy must leave the result alone
        stray_req = 1'b1;
        run_op(16'd50000, 12'd123);
        stray_req = 1'b0;
        idle_cycles(6);

        // random pairs, back to back unless a gap is drawn
        for (i = 0; i < num_ops; i++) begin
            draw_bits(16, r);
            a = r[15:0];
            draw_bits(12, r);
            b = r[11:0];
            // narrow divisors now and then for big quotients
            draw_bits(2, r);
            if (r[1:0] == 2'd0) begin
                b = b & 12'h00f;
            end else if (r[1:0] == 2'd1) begin
                b = b & 12'h0ff;
            end
            draw_bits(3, r);
            if (r[2:0] == 3'b111) begin
                idle_cycles(1);
            end
            run_op(a, b);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== test/div_chk.sv ====
// divider handshake assertions
`timescale 1ns/10ps

module div_chk (
    input logic clk,
    input logic rst_n,
    input logic in_vld,
    input logic busy,
    input logic out_vld
);

    logic accept;

    // request taken only while idle
    assign accept = in_vld && !busy;

    // ------------------------------------------------------------------------
    // handshake and latency
    // ------------------------------------------------------------------------

    // single cycle result strobe
    a_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld |=> !out_vld)
        else $error("out_vld stayed high for more than one cycle");

    // load at edge k, strobe seen at edge k+6, valid after edge k+5
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accept, 6) |-> out_vld)
        else $error("out_vld missing five cycles after an accepted request");

    // every strobe traces back to one accepted request
    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld |-> $past(accept, 6))
        else $error("out_vld without a matching accepted request");

    a_rst_idle: assert property (@(posedge clk) !rst_n |-> !busy)
        else $error("busy high during reset");

endmodule

// attach to the divider top
bind div_top div_chk i_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_vld  (in_vld),
    .busy    (busy),
    .out_vld (out_vld)
);

// ==== logic/div_top.sv ====
// radix 16 unsigned divider top
`timescale 1ns/10ps

module div_top import div_types_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_vld,
    input  dividend_t dividend,
    input  divisor_t  divisor,
    output logic      busy,
    output logic      out_vld,
    output dividend_t quo,
    output divisor_t  rem
);

    // controller strobes
    logic     load;
    logic     step_en;

    // datapath nets
    logic     div_zero;
    divisor_t part_rem;
    divisor_t rem_mid;
    divisor_t rem_next;
    digit_t   digit_hi;
    digit_t   digit_lo;

    // multiples and nibble shared by prep and the units
    div_operand_if ops ();

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    div_ctrl i_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_vld  (in_vld),
        .load    (load),
        .step_en (step_en),
        .out_vld (out_vld),
        .busy    (busy)
    );

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    div_operand_prep i_prep (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .step_en  (step_en),
        .dividend (dividend),
        .divisor  (divisor),
        .ops      (ops.prep),
        .div_zero (div_zero)
    );

    // upper nibble bits
    div_radix4_unit i_unit_hi (
        .ops     (ops.unit),
        .rem_in  (part_rem),
        .bits    (ops.nibble[3:2]),
        .digit   (digit_hi),
        .rem_out (rem_mid)
    );

    // lower nibble bits, chained off the hi unit
    div_radix4_unit i_unit_lo (
        .ops     (ops.unit),
        .rem_in  (rem_mid),
        .bits    (ops.nibble[1:0]),
        .digit   (digit_lo),
        .rem_out (rem_next)
    );

    div_result_reg i_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .step_en      (step_en),
        .div_zero     (div_zero),
        .dividend_lsb (dividend[divisor_w-1:0]),
        .digit_hi     (digit_hi),
        .digit_lo     (digit_lo),
        .rem_next     (rem_next),
        .part_rem     (part_rem),
        .quo          (quo),
        .rem          (rem)
    );

endmodule

// ==== logic/div_result_reg.sv ====
// quotient and remainder registers
`timescale 1ns/10ps

module div_result_reg import div_types_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  logic      step_en,
    input  logic      div_zero,
    input  divisor_t  dividend_lsb,
    input  digit_t    digit_hi,
    input  digit_t    digit_lo,
    input  divisor_t  rem_next,
    output divisor_t  part_rem,
    output dividend_t quo,
    output divisor_t  rem
);

    dividend_t quo_q;
    divisor_t  rem_q;
    divisor_t  lsb_q;

    // ------------------------------------------------------------------------
    // quotient shift and partial remainder
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quo_q <= '0;
            rem_q <= '0;
        end else if (load) begin
            // fresh division starts from zero remainder
            quo_q <= '0;
            rem_q <= '0;
        end else if (step_en) begin
            // four quotient bits per step, hi unit first
            quo_q <= {quo_q[dividend_w-nibble_w-1:0], digit_hi, digit_lo};
            rem_q <= rem_next;
        end
    end

    // low dividend bits kept for the divide by zero result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsb_q <= '0;
        end else if (load) begin
            lsb_q <= dividend_lsb;
        end
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------

    // feeds the hi unit on the next step
    assign part_rem = rem_q;

    // divide by zero gives all ones and the dividend low bits
    assign quo = div_zero ? '1    : quo_q;
    assign rem = div_zero ? lsb_q : rem_q;

endmodule

// ==== logic/div_radix4_unit.sv ====
// two bit restoring division unit
`timescale 1ns/10ps

module div_radix4_unit import div_types_pkg::*; (
    div_operand_if.unit ops,
    input  divisor_t    rem_in,
    input  logic [1:0]  bits,
    output digit_t      digit,
    output divisor_t    rem_out
);

    multiple_t trial;
    multiple_t diff_3b;
    multiple_t diff_2b;
    multiple_t diff_b;

    // partial remainder shifted by two, next dividend bits in
    assign trial = {1'b0, rem_in, bits};

    // trial subtractions, msb is the sign
    assign diff_3b = trial - ops.mult_3b;
    assign diff_2b = trial - ops.mult_2b;
    assign diff_b  = trial - ops.mult_b;

    // largest multiple that still fits wins
    always_comb begin
        if (!diff_3b[multiple_w-1]) begin
            digit   = digit_t'(3);
            rem_out = diff_3b[divisor_w-1:0];
        end else if (!diff_2b[multiple_w-1]) begin
            digit   = digit_t'(2);
            rem_out = diff_2b[divisor_w-1:0];
        end else if (!diff_b[multiple_w-1]) begin
            digit   = digit_t'(1);
            rem_out = diff_b[divisor_w-1:0];
        end else begin
            // nothing fits, remainder passes through
            digit   = digit_t'(0);
            rem_out = trial[divisor_w-1:0];
        end
    end

endmodule

// ==== logic/div_operand_prep.sv ====
// divider operand preparation
`timescale 1ns/10ps

module div_operand_prep import div_types_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic       step_en,
    input  dividend_t  dividend,
    input  divisor_t   divisor,
    div_operand_if.prep ops,
    output logic       div_zero
);

    dividend_t a_sft;
    divisor_t  divisor_nz;
    logic      divisor_is_zero;
    multiple_t mult_b_nxt;
    multiple_t mult_2b_nxt;
    multiple_t mult_3b_nxt;
    multiple_t mult_b_q;
    multiple_t mult_2b_q;
    multiple_t mult_3b_q;

    // ------------------------------------------------------------------------
    // divisor multiples
    // ------------------------------------------------------------------------

    assign divisor_is_zero = (divisor == '0);
    // zero divisor runs as one, output gets overridden later
    assign divisor_nz      = divisor_is_zero ? divisor_t'(1) : divisor;

    assign mult_b_nxt  = multiple_t'(divisor_nz);
    assign mult_2b_nxt = multiple_t'({divisor_nz, 1'b0});
    // 3b = 2b + b
    assign mult_3b_nxt = mult_2b_nxt + mult_b_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mult_b_q  <= '0;
            mult_2b_q <= '0;
            mult_3b_q <= '0;
            div_zero  <= 1'b0;
        end else if (load) begin
            mult_b_q  <= mult_b_nxt;
            mult_2b_q <= mult_2b_nxt;
            mult_3b_q <= mult_3b_nxt;
            div_zero  <= divisor_is_zero;
        end
    end

    // ------------------------------------------------------------------------
    // dividend nibble shifter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_sft <= '0;
        end else if (load) begin
            a_sft <= dividend;
        end else if (step_en) begin
            // msb nibble first
            a_sft <= {a_sft[dividend_w-nibble_w-1:0], {nibble_w{1'b0}}};
        end
    end

    assign ops.mult_b  = mult_b_q;
    assign ops.mult_2b = mult_2b_q;
    assign ops.mult_3b = mult_3b_q;
    assign ops.nibble  = a_sft[dividend_w-1 -: nibble_w];

endmodule

// ==== logic/div_ctrl.sv ====
// divider control FSM
`timescale 1ns/10ps

module div_ctrl import div_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_vld,
    output logic load,
    output logic step_en,
    output logic out_vld,
    output logic busy
);

    div_state_e state;
    div_state_e state_nxt;
    step_cnt_t  step_cnt;
    logic       accept;
    logic       last_step;

    // request only taken while idle
    assign accept    = (state == st_idle) && in_vld;
    // final nibble step in flight
    assign last_step = step_en && (step_cnt == step_cnt_t'(num_steps - 1));

    // ------------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // run holds one extra cycle after the last step, so done lands at k+5
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // steps finished, result registers settled
                if (!step_en) begin
                    state_nxt = st_done;
                end
            end
            st_done: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // step enable and step counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_en  <= 1'b0;
            step_cnt <= '0;
        end else if (accept) begin
            // steps start right after the load edge
            step_en  <= 1'b1;
            step_cnt <= '0;
        end else if (step_en) begin
            step_cnt <= step_cnt + step_cnt_t'(1);
            if (last_step) begin
                step_en <= 1'b0;
            end
        end
    end

    // load coincides with acceptance
    assign load    = accept;
    // single cycle result strobe
    assign out_vld = (state == st_done);
    // run and done both block new requests
    assign busy    = (state != st_idle);

endmodule

// ==== logic/div_operand_if.sv ====
// divisor multiples and dividend nibble bundle
`timescale 1ns/10ps

interface div_operand_if import div_types_pkg::*; ();

    // registered divisor multiples
    multiple_t mult_b;
    multiple_t mult_2b;
    multiple_t mult_3b;

    // current top nibble of the dividend shifter
    nibble_t   nibble;

    // operand prep side
    modport prep (
        output mult_b,
        output mult_2b,
        output mult_3b,
        output nibble
    );

    // restoring unit side
    modport unit (
        input  mult_b,
        input  mult_2b,
        input  mult_3b,
        input  nibble
    );

endinterface

// ==== logic/div_ctrl_pkg.sv ====
// divider controller definitions
package div_ctrl_pkg;

    // ------------------------------------------------------------------------
    // controller FSM
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

    // nibble iterations, dividend width over four
    localparam int num_steps = 4;

    // counts 0 .. num_steps-1
    typedef logic [1:0] step_cnt_t;

endpackage

// ==== logic/div_types_pkg.sv ====
// divider datapath types
package div_types_pkg;

    // ------------------------------------------------------------------------
    // operand widths
    // ------------------------------------------------------------------------

    // dividend and quotient width
    localparam int dividend_w = 16;
    // divisor and remainder width
    localparam int divisor_w  = 12;
    // divisor plus three guard bits, room for 3b and a sign
    localparam int multiple_w = divisor_w + 3;
    // dividend bits retired per clock
    localparam int nibble_w   = 4;
    // quotient bits per restoring unit
    localparam int digit_w    = 2;

    // ------------------------------------------------------------------------
    // word types
    // ------------------------------------------------------------------------

    typedef logic [dividend_w-1:0] dividend_t;
    typedef logic [divisor_w-1:0]  divisor_t;
    // b, 2b, 3b and trial differences
    typedef logic [multiple_w-1:0] multiple_t;
    typedef logic [digit_w-1:0]    digit_t;
    typedef logic [nibble_w-1:0]   nibble_t;

endpackage
